// File: rtl/panel_ctrl_pkg.sv
// ------------------
// Constants assume a 50 MHz clock_50.
// Host control word is 32 bits wide.
// ------------------
package panel_ctrl_pkg;

    // PWM period in prescaled ticks.
    // Also the full brightness value.
    localparam int pwm_max_value = 1000;

    // Width of brightness and PWM counter.
    localparam int pwm_bits = 10;

    // 50 MHz / 250 / 1000 gives 200 Hz.
    // Faster rates whine audibly in the backlight driver.
    localparam int pwm_prescale_default = 250;

    // 10 ms at 50 MHz.
    localparam int debounce_cycles_default = 500000;

    // Host control word layout.
    // Bit 0 is left over from the rasterizer and unused here.
    localparam int ctrl_override_bit = 1;

    // Brightness field sits in bits 11 to 2.
    localparam int ctrl_brightness_lsb = 2;

    // Host echoes the home status it has seen.
    localparam int ctrl_home_ack_bit = 12;

    // Brightness from 0 to pwm_max_value.
    // Larger codes get clamped by the PWM block.
    typedef logic [pwm_bits-1:0] brightness_t;

    // Debouncer states.
    // Two stable states and two transient ones.
    typedef enum logic [1:0] {
        db_released,
        db_pressing,
        db_pressed,
        db_releasing
    } debounce_state_t;

endpackage

// File: rtl/backlight_pwm.sv
// ------------------
// Brightness above pwm_max_value is clamped.
// prescale must be 1 or more.
// ------------------
`timescale 1ns/1ps

module backlight_pwm #(
    parameter int prescale = panel_ctrl_pkg::pwm_prescale_default
) (
    input  logic                      clock_50,
    input  logic                      reset_n,
    input  panel_ctrl_pkg::brightness_t brightness,
    output logic                      pwm_out
);

    // Prescale counter width.
    // Kept at one bit when prescale is 1.
    localparam int prescale_bits = (prescale > 1) ? $clog2(prescale) : 1;

    logic [prescale_bits-1:0]         prescale_count;
    logic                             pwm_tick;
    logic [panel_ctrl_pkg::pwm_bits-1:0] period_count;
    panel_ctrl_pkg::brightness_t      clamped_brightness;

    // Prescaler.
    // Wraps after prescale cycles.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            prescale_count <= '0;
        end else if (pwm_tick) begin
            prescale_count <= '0;
        end else begin
            prescale_count <= prescale_count + 1'b1;
        end
    end

    // One tick on the last prescaler count.
    assign pwm_tick = (prescale_count == prescale_bits'(prescale - 1));

    // Period counter.
    // Runs 0 to pwm_max_value minus 1, one step per tick.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            period_count <= '0;
        end else if (pwm_tick) begin
            if (period_count == panel_ctrl_pkg::pwm_bits'(panel_ctrl_pkg::pwm_max_value - 1))
            begin
                period_count <= '0;
            end else begin
                period_count <= period_count + 1'b1;
            end
        end
    end

    // Clamp out-of-range codes to full scale.
    // 10 bits reach 1023, the period only 1000.
    always_comb begin
        if (brightness > panel_ctrl_pkg::brightness_t'(panel_ctrl_pkg::pwm_max_value)) begin
            clamped_brightness = panel_ctrl_pkg::brightness_t'(panel_ctrl_pkg::pwm_max_value);
        end else begin
            clamped_brightness = brightness;
        end
    end

    // Registered compare.
    // High while counter is below brightness.
    // Zero never goes high, full scale never goes low.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            pwm_out <= 1'b0;
        end else begin
            pwm_out <= (period_count < clamped_brightness);
        end
    end

    // Counter never reaches the period length.
    // Otherwise full brightness would drop low for a tick.
    period_in_range: assert property (
        @(posedge clock_50) disable iff (!reset_n)
        period_count < panel_ctrl_pkg::pwm_max_value
    ) else $error("backlight_pwm period counter out of range: %0d", period_count);

endmodule

// File: rtl/button_debouncer.sv
// ------------------
// Input is active high here.
// debounce_cycles must be 2 or more.
// ------------------
`timescale 1ns/1ps

module button_debouncer #(
    parameter int debounce_cycles = panel_ctrl_pkg::debounce_cycles_default
) (
    input  logic clock_50,
    input  logic reset_n,
    input  logic raw_pressed,
    output logic pressed
);

    // Hold counter width, sized to reach debounce_cycles.
    localparam int hold_bits = $clog2(debounce_cycles + 1);

    logic [1:0]                      sync_ff;
    logic                            synced;
    logic [hold_bits-1:0]            hold_count;
    panel_ctrl_pkg::debounce_state_t state;

    // Two-flop synchronizer for the async pin.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            sync_ff <= 2'b00;
        end else begin
            sync_ff <= {sync_ff[0], raw_pressed};
        end
    end

    assign synced = sync_ff[1];

    // Debounce FSM.
    // Transient states count consecutive cycles at the new level.
    // Any glitch falls back to the stable state.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            state      <= panel_ctrl_pkg::db_released;
            hold_count <= '0;
        end else begin
            case (state)
                panel_ctrl_pkg::db_released: begin
                    // First cycle at the new level counts as one.
                    if (synced) begin
                        state      <= panel_ctrl_pkg::db_pressing;
                        hold_count <= hold_bits'(1);
                    end
                end
                panel_ctrl_pkg::db_pressing: begin
                    if (!synced) begin
                        state <= panel_ctrl_pkg::db_released;
                    end else if (hold_count == hold_bits'(debounce_cycles - 1)) begin
                        state <= panel_ctrl_pkg::db_pressed;
                    end else begin
                        hold_count <= hold_count + 1'b1;
                    end
                end
                panel_ctrl_pkg::db_pressed: begin
                    if (!synced) begin
                        state      <= panel_ctrl_pkg::db_releasing;
                        hold_count <= hold_bits'(1);
                    end
                end
                panel_ctrl_pkg::db_releasing: begin
                    if (synced) begin
                        state <= panel_ctrl_pkg::db_pressed;
                    end else if (hold_count == hold_bits'(debounce_cycles - 1)) begin
                        state <= panel_ctrl_pkg::db_released;
                    end else begin
                        hold_count <= hold_count + 1'b1;
                    end
                end
                default: begin
                    state <= panel_ctrl_pkg::db_released;
                end
            endcase
        end
    end

    // Output stays high until release is confirmed.
    assign pressed = (state == panel_ctrl_pkg::db_pressed) ||
                     (state == panel_ctrl_pkg::db_releasing);

    // Hold counter bounded by the debounce length.
    hold_in_range: assert property (
        @(posedge clock_50) disable iff (!reset_n)
        hold_count <= debounce_cycles
    ) else $error("button_debouncer hold counter overran: %0d", hold_count);

endmodule

// File: rtl/home_button_handshake.sv
// ------------------
// Host must echo home_status on host_ack.
// Changes are held until it does.
// ------------------
`timescale 1ns/1ps

module home_button_handshake (
    input  logic clock_50,
    input  logic reset_n,
    input  logic pressed,
    input  logic host_ack,
    output logic home_status
);

    logic allow_update;

    // Host has seen the current status.
    // Only then may a new value go out.
    assign allow_update = (home_status == host_ack);

    // Status register.
    // Holds while the host has not acknowledged.
    // Button changes in that time are not seen.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            home_status <= 1'b0;
        end else if (allow_update) begin
            home_status <= pressed;
        end
    end

    // Unacknowledged status is frozen for the next cycle.
    status_held: assert property (
        @(posedge clock_50) disable iff (!reset_n)
        (home_status != host_ack) |=> $stable(home_status)
    ) else $error("home_status changed before host ack");

endmodule

// File: rtl/panel_ctrl_top.sv
// ------------------
// home_button_pin is active low, pulled up on board.
// host_control bit 0 is ignored.
// ------------------
`timescale 1ns/1ps

module panel_ctrl_top #(
    parameter int prescale        = panel_ctrl_pkg::pwm_prescale_default,
    parameter int debounce_cycles = panel_ctrl_pkg::debounce_cycles_default
) (
    input  logic        clock_50,
    input  logic        reset_n,
    input  logic [31:0] host_control,
    input  logic        home_button_pin,
    output logic        backlight_pwm,
    output logic        home_status
);

    panel_ctrl_pkg::brightness_t pwm_brightness;
    logic                        raw_pressed;
    logic                        debounced_pressed;
    logic                        home_ack;

    // Host brightness once it takes over.
    // Full brightness at power-on, before software runs.
    assign pwm_brightness = host_control[panel_ctrl_pkg::ctrl_override_bit] ?
        host_control[panel_ctrl_pkg::ctrl_brightness_lsb +: panel_ctrl_pkg::pwm_bits] :
        panel_ctrl_pkg::brightness_t'(panel_ctrl_pkg::pwm_max_value);

    // Pin pulls low when pressed.
    assign raw_pressed = ~home_button_pin;

    // Ack echo from the host.
    assign home_ack = host_control[panel_ctrl_pkg::ctrl_home_ack_bit];

    // Backlight PWM.
    backlight_pwm #(
        .prescale (prescale)
    ) pwm0 (
        .clock_50   (clock_50),
        .reset_n    (reset_n),
        .brightness (pwm_brightness),
        .pwm_out    (backlight_pwm)
    );

    // Home button debounce.
    button_debouncer #(
        .debounce_cycles (debounce_cycles)
    ) debouncer0 (
        .clock_50    (clock_50),
        .reset_n     (reset_n),
        .raw_pressed (raw_pressed),
        .pressed     (debounced_pressed)
    );

    // Status bit to the host.
    home_button_handshake handshake0 (
        .clock_50    (clock_50),
        .reset_n     (reset_n),
        .pressed     (debounced_pressed),
        .host_ack    (home_ack),
        .home_status (home_status)
    );

endmodule

// File: testbench/tb_panel_ctrl.sv
// --------------------
// Reads testbench/panel_ctrl_input.txt from the project root.
// DUT runs with prescale 2 and debounce_cycles 16.
// --------------------
`timescale 1ns/1ps

module tb_panel_ctrl;

    // Short parameters keep the run small.
    localparam int prescale_tb   = 2;
    localparam int debounce_tb   = 16;
    localparam int period_cycles = panel_ctrl_pkg::pwm_max_value * prescale_tb;
    localparam int status_window = debounce_tb + 10;
    localparam int ack_window    = 5;
    localparam int max_bounce    = 12;
    localparam string input_path = "testbench/panel_ctrl_input.txt";

    logic        clock_50;
    logic        reset_n;
    logic [31:0] host_control;
    logic        home_button_pin;
    logic        backlight_pwm;
    logic        home_status;

    logic [31:0] lfsr_state;
    int          line_count;

    // Host word fields kept between steps.
    logic        cur_override;
    logic [9:0]  cur_bright;
    logic        cur_ack;

    panel_ctrl_top #(
        .prescale        (prescale_tb),
        .debounce_cycles (debounce_tb)
    ) dut0 (
        .clock_50        (clock_50),
        .reset_n         (reset_n),
        .host_control    (host_control),
        .home_button_pin (home_button_pin),
        .backlight_pwm   (backlight_pwm),
        .home_status     (home_status)
    );

    // 50 MHz.
    always #10 clock_50 = ~clock_50;

    // 32-bit Fibonacci LFSR with taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // Four bits with one LFSR step each.
    // Mapped onto 1 to 12 cycles.
    task automatic pick_bounce_length(output int length);
        logic [3:0] bits;
        int         i;
        bits = '0;
        for (i = 0; i < 4; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[2:0], lfsr_state[0]};
        end
        length = (int'(bits) % max_bounce) + 1;
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("FAIL at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch on %s.", name);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        $display("RESULT: FAIL");
        $fatal(1, "%s", reason);
    endtask

    // Whitespace between step fields.
    function automatic logic is_blank(input logic [7:0] c);
        return (c == 8'd32) || (c == 8'd10) || (c == 8'd13) || (c == 8'd9);
    endfunction

    // Host word goes out on the next rising edge.
    task automatic drive_control();
        logic [31:0] word;
        word = '0;
        word[panel_ctrl_pkg::ctrl_override_bit] = cur_override;
        word[panel_ctrl_pkg::ctrl_brightness_lsb +: panel_ctrl_pkg::pwm_bits] = cur_bright;
        word[panel_ctrl_pkg::ctrl_home_ack_bit] = cur_ack;
        @(posedge clock_50);
        host_control <= word;
    endtask

    // Pin held at one level while the status is checked every cycle.
    task automatic hold_pin(input logic level, input int cycles, input int held_status);
        repeat (cycles) begin
            @(posedge clock_50);
            home_button_pin <= level;
            @(negedge clock_50);
            check_value("home_status", held_status, int'(home_status));
        end
    endtask

    // Called just after a falling edge.
    task automatic await_status(input int expected, input int window);
        int waited;
        waited = 0;
        if (int'(home_status) != expected) begin
            // Poll for the change within the window.
            while (int'(home_status) != expected && waited < window) begin
                @(negedge clock_50);
                waited++;
            end
            check_value("home_status", expected, int'(home_status));
        end else begin
            // No change due, so it must hold for the whole window.
            repeat (window) begin
                @(negedge clock_50);
                check_value("home_status", expected, int'(home_status));
            end
        end
    endtask

    task automatic run_brightness_step(input int override, input int bright, input int expected);
        int high_count;
        high_count = 0;
        cur_override = override[0];
        cur_bright = bright[9:0];
        drive_control();
        // Let the new duty take hold for one full period.
        repeat (period_cycles) @(posedge clock_50);
        repeat (period_cycles) begin
            @(negedge clock_50);
            if (backlight_pwm) begin
                high_count++;
            end
        end
        check_value("backlight_pwm high cycles", expected, high_count);
    endtask

    // Bounces come before the stable level.
    // Each bounce is a run at the target level and a run back.
    task automatic run_button_step(input int pressed, input int bounces, input int expected);
        int   held;
        int   length;
        int   i;
        logic target_pin;
        held = int'(home_status);
        target_pin = ~pressed[0];
        for (i = 0; i < bounces; i++) begin
            pick_bounce_length(length);
            hold_pin(target_pin, length, held);
            pick_bounce_length(length);
            hold_pin(~target_pin, length, held);
        end
        @(posedge clock_50);
        home_button_pin <= target_pin;
        @(negedge clock_50);
        await_status(expected, status_window);
    endtask

    task automatic run_ack_step(input int ack, input int expected);
        cur_ack = ack[0];
        drive_control();
        @(negedge clock_50);
        await_status(expected, ack_window);
    endtask

    // Budget of 3000 cycles per stimulus line.
    initial begin : watchdog
        wait (line_count > 0);
        repeat (line_count * 3000) @(posedge clock_50);
        $display("Timeout: steps did not finish within %0d cycles", line_count * 3000);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired.");
    end

    initial begin : main_sequence
        int         fd;
        int         code;
        int         op_a;
        int         op_b;
        int         expected;
        logic [7:0] kind;
        string      text;
        clock_50        = 1'b0;
        reset_n         = 1'b0;
        host_control    = '0;
        home_button_pin = 1'b1;
        lfsr_state      = 32'h7df3_6be7;
        line_count      = 0;
        cur_override    = 1'b0;
        cur_bright      = '0;
        cur_ack         = 1'b0;

        // First pass only counts lines.
        fd = $fopen(input_path, "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file");
        end
        while (!$feof(fd)) begin
            code = $fgets(text, fd);
            if (code > 0) begin
                line_count++;
            end
        end
        $fclose(fd);

        // Outputs are checked in the last of five reset cycles.
        repeat (4) @(posedge clock_50);
        @(negedge clock_50);
        check_value("backlight_pwm", 0, int'(backlight_pwm));
        check_value("home_status", 0, int'(home_status));
        @(posedge clock_50);
        reset_n <= 1'b1;
        @(negedge clock_50);

        // Step lines are a letter and three numbers.
        fd = $fopen(input_path, "r");
        code = $fscanf(fd, "%c", kind);
        while (code == 1) begin
            if (kind == "#") begin
                code = $fgets(text, fd);
            end else if (kind == "B" || kind == "P" || kind == "A") begin
                code = $fscanf(fd, "%d %d %d", op_a, op_b, expected);
                if (code != 3) begin
                    abort_run("malformed step line in the stimulus file");
                end
                case (kind)
                    "B": run_brightness_step(op_a, op_b, expected);
                    "P": run_button_step(op_a, op_b, expected);
                    default: run_ack_step(op_a, expected);
                endcase
            end else if (!is_blank(kind)) begin
                abort_run("unknown step kind in the stimulus file");
            end
            code = $fscanf(fd, "%c", kind);
        end
        $fclose(fd);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: testbench/panel_ctrl_input.txt
# Columns: kind op_a op_b expected, one step per line.
# B override brightness high_cycles | P pressed bounces home_status | A ack unused home_status
# Full brightness before the host takes over.
B 0 0 2000
# Duty cycle, two clock cycles per PWM tick.
B 1 1 2
B 1 250 500
B 1 500 1000
B 1 999 1998
# Extremes and clamping.
B 1 0 0
B 1 1000 2000
B 1 1023 2000
# Bounces alone never reach the debounce length.
P 0 4 0
# Press while the ack matches the status.
P 1 3 1
# No ack yet, so release and re-press stay hidden.
P 0 2 1
P 1 2 1
# Ack with the button still down.
A 1 0 1
# Release now shows up.
P 0 3 0
A 0 0 0
# Press, release before the ack, then the ack exposes the release.
P 1 4 1
P 0 2 1
A 1 0 0
# Status 0 against ack 1 holds a new press back.
P 1 2 0
A 0 0 1
A 1 0 1
P 0 1 0
A 0 0 0
# Bounce on a released button.
P 0 5 0
# Override off, brightness field ignored.
B 0 300 2000
# Override back on.
B 1 100 200
B 1 750 1500
# Press and release once more with matching acks.
P 1 2 1
A 1 0 1
P 0 2 0
A 0 0 0

// File: verilog.f
rtl/panel_ctrl_pkg.sv
rtl/backlight_pwm.sv
rtl/button_debouncer.sv
rtl/home_button_handshake.sv
rtl/panel_ctrl_top.sv
testbench/tb_panel_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the panel control testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_panel_ctrl -f verilog.f -o sim_panel_ctrl > build.log 2>&1 \
    && ./obj_dir/sim_panel_ctrl > sim.log 2>&1 \
    || echo "Build or simulation returned an error status"

grep -qs "^RESULT: PASS$" sim.log \
    && echo "Simulation passed" \
    && exit 0 \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
